//--- all.f
+incdir+bench
src/commit_pkg.sv
src/gpr_file.sv
src/csr_file.sv
src/trap_unit.sv
src/commit_stage.sv
bench/commit_stage_tb.sv

//--- Makefile
# Verilator build and run for the commit stage testbench

VERILATOR ?= verilator
TOP       ?= commit_stage_tb
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
FILELIST  ?= all.f
VFLAGS    ?= --binary --assert -j 0
PASS_TEXT ?= all tests passed

SOURCES := $(wildcard src/*.sv bench/*.sv bench/*.svh)
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_TEXT)" $(LOG) || (echo "Simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/commit_vectors.svh
// One row per cycle. First line of a row is the stimulus:
//   rd wen wrand wdata csr_d csr_wen crand csr_wdata events lsu_pc exu_npc
// Second line holds the read addresses sampled after the edge and the expected outputs:
//   rs1 rs2 csr_s use_rand src1 src2 csr_src flush clear_cache npc

typedef struct packed {
  logic [4:0]                rd;
  logic                      wen;
  logic                      wrand;      // wdata comes from $urandom
  logic [xlen-1:0]           wdata;
  logic [csr_addr_width-1:0] csr_d;
  logic                      csr_wen;
  logic                      crand;      // csr_wdata comes from $urandom
  logic [xlen-1:0]           csr_wdata;
  logic [3:0]                events;     // misaligned, ecall, fence_i, wrong_prediction
  logic [xlen-1:0]           lsu_pc;
  logic [xlen-1:0]           exu_npc;
  logic [4:0]                rs1;
  logic [4:0]                rs2;
  logic [csr_addr_width-1:0] csr_s;
  logic [2:0]                use_rand;   // Latest random word on csr_src, src2, src1
  logic [xlen-1:0]           src1;
  logic [xlen-1:0]           src2;
  logic [xlen-1:0]           csr_src;
  logic                      flush;
  logic                      clear_cache;
  logic [xlen-1:0]           npc;
} vector_t;

localparam int vector_count = 26;

vector_t vectors [vector_count] = '{
  '{5'd0, 1'b0, 1'b0, 32'h0, 12'h000, 1'b0, 1'b0, 32'h0, 4'b0000, 32'h0, 32'h8000_0004,
    5'd0, 5'd1, csr_mstatus, 3'b000, 32'h0, 32'h0, mstatus_reset, 1'b0, 1'b0, 32'h8000_0004},
  '{5'd0, 1'b0, 1'b0, 32'h0, 12'h000, 1'b0, 1'b0, 32'h0, 4'b0000, 32'h0, 32'h8000_0008,
    5'd2, 5'd15, csr_mvendorid, 3'b000, 32'h0, 32'h0, mvendorid_value, 1'b0, 1'b0,
    32'h8000_0008},
  '{5'd0, 1'b0, 1'b0, 32'h0, 12'h000, 1'b0, 1'b0, 32'h0, 4'b0000, 32'h0, 32'h8000_000C,
    5'd3, 5'd4, csr_marchid, 3'b000, 32'h0, 32'h0, marchid_value, 1'b0, 1'b0, 32'h8000_000C},
  // GPR writes, x0 and index 16 stay zero
  '{5'd1, 1'b1, 1'b1, 32'h0, 12'h000, 1'b0, 1'b0, 32'h0, 4'b0000, 32'h0, 32'h8000_0010,
    5'd1, 5'd5, csr_mtvec, 3'b001, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0, 32'h8000_0010},
  '{5'd15, 1'b1, 1'b1, 32'h0, 12'h000, 1'b0, 1'b0, 32'h0, 4'b0000, 32'h0, 32'h8000_0014,
    5'd15, 5'd15, csr_mepc, 3'b011, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0, 32'h8000_0014},
  '{5'd0, 1'b1, 1'b0, 32'hDEAD_BEEF, 12'h000, 1'b0, 1'b0, 32'h0, 4'b0000, 32'h0, 32'h8000_0018,
    5'd0, 5'd6, csr_mcause, 3'b000, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0, 32'h8000_0018},
  '{5'd16, 1'b1, 1'b0, 32'h1234_5678, 12'h000, 1'b0, 1'b0, 32'h0, 4'b0000, 32'h0,
    32'h8000_001C, 5'd0, 5'd7, 12'h7C0, 3'b000, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0, 32'h8000_001C},
  // CSR writes
  '{5'd0, 1'b0, 1'b0, 32'h0, csr_mstatus, 1'b1, 1'b0, 32'h0000_0088, 4'b0000, 32'h0,
    32'h8000_0020, 5'd8, 5'd9, csr_mstatus, 3'b000, 32'h0, 32'h0, 32'h0000_0088, 1'b0, 1'b0,
    32'h8000_0020},
  '{5'd0, 1'b0, 1'b0, 32'h0, csr_mtvec, 1'b1, 1'b0, 32'h8000_0100, 4'b0000, 32'h0,
    32'h8000_0024, 5'd10, 5'd11, csr_mtvec, 3'b000, 32'h0, 32'h0, 32'h8000_0100, 1'b0, 1'b0,
    32'h8000_0024},
  '{5'd0, 1'b0, 1'b0, 32'h0, csr_mepc, 1'b1, 1'b1, 32'h0, 4'b0000, 32'h0, 32'h8000_0028,
    5'd12, 5'd13, csr_mepc, 3'b100, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0, 32'h8000_0028},
  '{5'd0, 1'b0, 1'b0, 32'h0, csr_mcause, 1'b1, 1'b0, 32'h0000_0055, 4'b0000, 32'h0,
    32'h8000_002C, 5'd15, 5'd14, csr_mcause, 3'b001, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0,
    32'h8000_002C},
  '{5'd0, 1'b0, 1'b0, 32'h0, 12'h7C0, 1'b1, 1'b0, 32'hFFFF_FFFF, 4'b0000, 32'h0, 32'h8000_0030,
    5'd0, 5'd0, 12'h7C0, 3'b000, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0, 32'h8000_0030},
  // Traps, each followed by a flush cycle
  '{5'd5, 1'b1, 1'b0, 32'h0000_0005, 12'h000, 1'b0, 1'b0, 32'h0, 4'b0100, 32'h8000_0040,
    32'h8000_0044, 5'd0, 5'd0, csr_mcause, 3'b000, 32'h0, 32'h0, 32'd11, 1'b1, 1'b0,
    32'h8000_0100},
  '{5'd7, 1'b1, 1'b0, 32'h7777_7777, csr_mtvec, 1'b1, 1'b0, 32'h1111_1111, 4'b0100,
    32'h8000_0050, 32'h9999_0000, 5'd5, 5'd15, csr_mepc, 3'b010, 32'h5, 32'h0, 32'h8000_0040,
    1'b0, 1'b0, 32'h8000_0100},
  '{5'd0, 1'b0, 1'b0, 32'h0, 12'h000, 1'b0, 1'b0, 32'h0, 4'b1000, 32'h8000_0102, 32'h8000_0108,
    5'd7, 5'd0, csr_mcause, 3'b000, 32'h0, 32'h0, 32'd0, 1'b1, 1'b0, 32'h8000_0100},
  '{5'd0, 1'b0, 1'b0, 32'h0, 12'h000, 1'b0, 1'b0, 32'h0, 4'b0000, 32'h0, 32'h8000_0110,
    5'd0, 5'd0, csr_mtvec, 3'b000, 32'h0, 32'h0, 32'h8000_0100, 1'b0, 1'b0, 32'h8000_0100},
  '{5'd0, 1'b0, 1'b0, 32'h0, 12'h000, 1'b0, 1'b0, 32'h0, 4'b0100, 32'h8000_0104, 32'h8000_0108,
    5'd0, 5'd0, csr_mcause, 3'b000, 32'h0, 32'h0, 32'd11, 1'b1, 1'b0, 32'h8000_0100},
  '{5'd0, 1'b0, 1'b0, 32'h0, 12'h000, 1'b0, 1'b0, 32'h0, 4'b0000, 32'h0, 32'h8000_0110,
    5'd0, 5'd0, csr_mepc, 3'b000, 32'h0, 32'h0, 32'h8000_0104, 1'b0, 1'b0, 32'h8000_0100},
  '{5'd0, 1'b0, 1'b0, 32'h0, 12'h000, 1'b0, 1'b0, 32'h0, 4'b1100, 32'h8000_0200, 32'h8000_0204,
    5'd0, 5'd0, csr_mcause, 3'b000, 32'h0, 32'h0, 32'd0, 1'b1, 1'b0, 32'h8000_0100},
  '{5'd0, 1'b0, 1'b0, 32'h0, 12'h000, 1'b0, 1'b0, 32'h0, 4'b0000, 32'h0, 32'h8000_0208,
    5'd0, 5'd0, csr_mepc, 3'b000, 32'h0, 32'h0, 32'h8000_0200, 1'b0, 1'b0, 32'h8000_0100},
  // fence.i, then a misprediction with all inputs ignored in its flush cycle
  '{5'd0, 1'b0, 1'b0, 32'h0, 12'h000, 1'b0, 1'b0, 32'h0, 4'b0010, 32'h0, 32'h8000_0300,
    5'd0, 5'd0, csr_mstatus, 3'b000, 32'h0, 32'h0, 32'h0000_0088, 1'b1, 1'b1, 32'h8000_0300},
  '{5'd0, 1'b0, 1'b0, 32'h0, 12'h000, 1'b0, 1'b0, 32'h0, 4'b0000, 32'h0, 32'h8000_0400,
    5'd0, 5'd0, csr_mstatus, 3'b000, 32'h0, 32'h0, 32'h0000_0088, 1'b0, 1'b1, 32'h8000_0300},
  '{5'd0, 1'b0, 1'b0, 32'h0, 12'h000, 1'b0, 1'b0, 32'h0, 4'b0001, 32'h0, 32'h8000_0500,
    5'd0, 5'd0, csr_mtvec, 3'b000, 32'h0, 32'h0, 32'h8000_0100, 1'b1, 1'b0, 32'h8000_0500},
  '{5'd5, 1'b1, 1'b0, 32'hABCD_0000, csr_mstatus, 1'b1, 1'b0, 32'h0, 4'b0100, 32'h8000_0600,
    32'h8000_0604, 5'd5, 5'd9, csr_mstatus, 3'b000, 32'h5, 32'h0, 32'h0000_0088, 1'b0, 1'b0,
    32'h8000_0500},
  '{5'd0, 1'b0, 1'b0, 32'h0, 12'h000, 1'b0, 1'b0, 32'h0, 4'b0000, 32'h0, 32'h8000_0504,
    5'd15, 5'd7, csr_mepc, 3'b001, 32'h0, 32'h0, 32'h8000_0200, 1'b0, 1'b0, 32'h8000_0504},
  '{5'd0, 1'b0, 1'b0, 32'h0, 12'h000, 1'b0, 1'b0, 32'h0, 4'b0000, 32'h0, 32'h8000_0508,
    5'd0, 5'd0, csr_mcause, 3'b000, 32'h0, 32'h0, 32'd0, 1'b0, 1'b0, 32'h8000_0508}
};

//--- bench/commit_stage_tb.sv
module commit_stage_tb;

  import commit_pkg::*;

  localparam int period       = 20;
  localparam int reset_cycles = 3;

  logic                      clock;
  logic                      reset;
  logic [4:0]                rs1;
  logic [4:0]                rs2;
  logic [4:0]                rd;
  logic                      wen;
  logic [xlen-1:0]           wdata;
  logic [csr_addr_width-1:0] csr_s;
  logic [csr_addr_width-1:0] csr_d;
  logic                      csr_wen;
  logic [xlen-1:0]           csr_wdata;
  logic                      inst_addr_misaligned;
  logic                      ecall;
  logic                      fence_i;
  logic                      wrong_prediction;
  logic [xlen-1:0]           lsu_pc;
  logic [xlen-1:0]           exu_npc;
  logic [xlen-1:0]           src1;
  logic [xlen-1:0]           src2;
  logic [xlen-1:0]           csr_src;
  logic                      flush;
  logic                      clear_cache;
  logic [xlen-1:0]           npc;

  `include "commit_vectors.svh"

  logic [xlen-1:0] row_wdata [vector_count];
  logic [xlen-1:0] row_csr_wdata [vector_count];
  logic [xlen-1:0] latest_wdata [vector_count];      // Newest random GPR word up to each row
  logic [xlen-1:0] latest_csr_wdata [vector_count];

  commit_stage commit_stage_i (.*);

  initial clock = 1'b0;
  always #(period / 2) clock = ~clock;

  // ##############################
  // Compare tasks
  // ##############################

  task automatic check_word(input string name, input logic [xlen-1:0] actual,
                            input logic [xlen-1:0] expected);
    if (actual !== expected) begin
      $display("Fail at %0t: %s is %h, expected %h", $time, name, actual, expected);
      $display("tests failed");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  task automatic check_bit(input string name, input logic actual, input logic expected);
    if (actual !== expected) begin
      $display("Fail at %0t: %s is %b, expected %b", $time, name, actual, expected);
      $display("tests failed");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  // ##############################
  // Stimulus
  // ##############################

  task automatic draw_random_data();
    for (int i = 0; i < vector_count; i++) begin
      row_wdata[i]     = vectors[i].wrand ? $urandom : vectors[i].wdata;
      row_csr_wdata[i] = vectors[i].crand ? $urandom : vectors[i].csr_wdata;
      if (vectors[i].wrand) latest_wdata[i] = row_wdata[i];
      else if (i > 0) latest_wdata[i] = latest_wdata[i-1];
      else latest_wdata[i] = '0;
      if (vectors[i].crand) latest_csr_wdata[i] = row_csr_wdata[i];
      else if (i > 0) latest_csr_wdata[i] = latest_csr_wdata[i-1];
      else latest_csr_wdata[i] = '0;
    end
  endtask

  task automatic apply_inputs(input int i);
    rd        <= vectors[i].rd;
    wen       <= vectors[i].wen;
    wdata     <= row_wdata[i];
    csr_d     <= vectors[i].csr_d;
    csr_wen   <= vectors[i].csr_wen;
    csr_wdata <= row_csr_wdata[i];
    {inst_addr_misaligned, ecall, fence_i, wrong_prediction} <= vectors[i].events;
    lsu_pc    <= vectors[i].lsu_pc;
    exu_npc   <= vectors[i].exu_npc;
  endtask

  task automatic apply_idle();
    wen     <= 1'b0;
    csr_wen <= 1'b0;
    {inst_addr_misaligned, ecall, fence_i, wrong_prediction} <= 4'b0000;
  endtask

  // Reads trail the row by one edge so they see its writes
  task automatic apply_reads(input int i);
    rs1   <= vectors[i].rs1;
    rs2   <= vectors[i].rs2;
    csr_s <= vectors[i].csr_s;
  endtask

  task automatic check_row(input int i);
    logic [xlen-1:0] exp_src1;
    logic [xlen-1:0] exp_src2;
    logic [xlen-1:0] exp_csr_src;
    exp_src1    = vectors[i].use_rand[0] ? latest_wdata[i] : vectors[i].src1;
    exp_src2    = vectors[i].use_rand[1] ? latest_wdata[i] : vectors[i].src2;
    exp_csr_src = vectors[i].use_rand[2] ? latest_csr_wdata[i] : vectors[i].csr_src;
    check_word("src1", src1, exp_src1);
    check_word("src2", src2, exp_src2);
    check_word("csr_src", csr_src, exp_csr_src);
    check_bit("flush", flush, vectors[i].flush);
    check_bit("clear_cache", clear_cache, vectors[i].clear_cache);
    check_word("npc", npc, vectors[i].npc);
  endtask

  initial begin
    void'($urandom(40288));
    reset     = 1'b1;
    {rs1, rs2, rd, wen, wdata} = '0;
    {csr_s, csr_d, csr_wen, csr_wdata} = '0;
    {inst_addr_misaligned, ecall, fence_i, wrong_prediction} = 4'b0000;
    lsu_pc    = '0;
    exu_npc   = '0;
    draw_random_data();
    repeat (reset_cycles) @(posedge clock);
    reset <= 1'b0;
    apply_inputs(0);
    @(negedge clock);
    check_bit("flush", flush, 1'b0);                 // State straight out of reset
    check_bit("clear_cache", clear_cache, 1'b0);
    check_word("npc", npc, reset_vector);
    for (int i = 0; i < vector_count; i++) begin
      @(posedge clock);
      if (i + 1 < vector_count) apply_inputs(i + 1);
      else apply_idle();
      apply_reads(i);
      @(negedge clock);
      check_row(i);
    end
    $display("all tests passed");
    $finish;
  end

  initial begin
    #((vector_count + reset_cycles + 10) * period);
    $display("Timeout: the vector loop did not complete in time");
    $display("tests failed");
    $fatal(1, "Watchdog expired");
  end

endmodule

//--- src/commit_stage.sv
module commit_stage (
  input  logic                                  clock,
  input  logic                                  reset,

  // GPR ports
  input  logic [4:0]                            rs1,
  input  logic [4:0]                            rs2,
  input  logic [4:0]                            rd,
  input  logic                                  wen,
  input  logic [commit_pkg::xlen-1:0]           wdata,

  // CSR ports
  input  logic [commit_pkg::csr_addr_width-1:0] csr_s,
  input  logic [commit_pkg::csr_addr_width-1:0] csr_d,
  input  logic                                  csr_wen,
  input  logic [commit_pkg::xlen-1:0]           csr_wdata,

  // Events from the last stage
  input  logic                                  inst_addr_misaligned,
  input  logic                                  ecall,
  input  logic                                  fence_i,
  input  logic                                  wrong_prediction,
  input  logic [commit_pkg::xlen-1:0]           lsu_pc,
  input  logic [commit_pkg::xlen-1:0]           exu_npc,

  output logic [commit_pkg::xlen-1:0]           src1,
  output logic [commit_pkg::xlen-1:0]           src2,
  output logic [commit_pkg::xlen-1:0]           csr_src,
  output logic                                  flush,
  output logic                                  clear_cache,
  output logic [commit_pkg::xlen-1:0]           npc
);

  import commit_pkg::*;

  logic            retire;
  logic            trap_take;
  logic            csr_commit;
  logic [xlen-1:0] trap_cause;
  logic [xlen-1:0] mtvec;

  gpr_file gpr_file_i (
    .clock (clock),
    .reset (reset),
    .rs1   (rs1),
    .rs2   (rs2),
    .rd    (rd),
    .wen   (wen),
    .retire(retire),
    .wdata (wdata),
    .src1  (src1),
    .src2  (src2)
  );

  csr_file csr_file_i (
    .clock     (clock),
    .reset     (reset),
    .csr_s     (csr_s),
    .csr_d     (csr_d),
    .csr_wen   (csr_wen),
    .csr_commit(csr_commit),
    .csr_wdata (csr_wdata),
    .trap_take (trap_take),
    .trap_cause(trap_cause),
    .trap_pc   (lsu_pc),      // PC of the retiring instruction
    .csr_src   (csr_src),
    .mtvec     (mtvec)
  );

  trap_unit trap_unit_i (
    .clock               (clock),
    .reset               (reset),
    .inst_addr_misaligned(inst_addr_misaligned),
    .ecall               (ecall),
    .fence_i             (fence_i),
    .wrong_prediction    (wrong_prediction),
    .exu_npc             (exu_npc),
    .mtvec               (mtvec),
    .retire              (retire),
    .trap_take           (trap_take),
    .csr_commit          (csr_commit),
    .trap_cause          (trap_cause),
    .flush               (flush),
    .clear_cache         (clear_cache),
    .npc                 (npc)
  );

endmodule

//--- src/trap_unit.sv
module trap_unit (
  input  logic                        clock,
  input  logic                        reset,

  input  logic                        inst_addr_misaligned,
  input  logic                        ecall,
  input  logic                        fence_i,
  input  logic                        wrong_prediction,

  input  logic [commit_pkg::xlen-1:0] exu_npc,
  input  logic [commit_pkg::xlen-1:0] mtvec,

  output logic                        retire,
  output logic                        trap_take,
  output logic                        csr_commit,
  output logic [commit_pkg::xlen-1:0] trap_cause,

  output logic                        flush,
  output logic                        clear_cache,
  output logic [commit_pkg::xlen-1:0] npc
);

  import commit_pkg::*;

  // ##############################
  // Retire and trap decode
  // ##############################

  assign retire     = !flush;  // Slot after a flush carries nothing
  assign trap_take  = retire && (inst_addr_misaligned || ecall);
  assign csr_commit = retire && !trap_take;

  // Misaligned fetch wins over ecall
  assign trap_cause = inst_addr_misaligned ? cause_misaligned : cause_ecall;

  // ##############################
  // Flush and next PC
  // ##############################

  always_ff @(posedge clock) begin
    if (reset) begin
      flush       <= 1'b0;
      clear_cache <= 1'b0;
      npc         <= reset_vector;
    end else if (!retire) begin
      flush <= 1'b0;               // npc and clear_cache hold
    end else if (trap_take) begin
      flush       <= 1'b1;
      clear_cache <= 1'b0;
      npc         <= mtvec;        // Enter handler
    end else begin
      flush       <= fence_i || wrong_prediction;
      clear_cache <= fence_i;
      npc         <= exu_npc;
    end
  end

  // Redirect always leaves one bubble and never two
  flush_single_cycle: assert property (
    @(posedge clock) disable iff (reset)
      flush |=> !flush
  );

endmodule

//--- src/csr_file.sv
module csr_file (
  input  logic                                  clock,
  input  logic                                  reset,

  input  logic [commit_pkg::csr_addr_width-1:0] csr_s,
  input  logic [commit_pkg::csr_addr_width-1:0] csr_d,
  input  logic                                  csr_wen,
  input  logic                                  csr_commit,
  input  logic [commit_pkg::xlen-1:0]           csr_wdata,

  input  logic                                  trap_take,
  input  logic [commit_pkg::xlen-1:0]           trap_cause,
  input  logic [commit_pkg::xlen-1:0]           trap_pc,

  output logic [commit_pkg::xlen-1:0]           csr_src,
  output logic [commit_pkg::xlen-1:0]           mtvec
);

  import commit_pkg::*;

  logic [xlen-1:0] mstatus;
  logic [xlen-1:0] mepc;
  logic [xlen-1:0] mcause;

  logic            sw_write;

  assign sw_write = csr_commit && csr_wen;

  // ##############################
  // State update
  // ##############################

  always_ff @(posedge clock) begin
    if (reset) begin
      mstatus <= mstatus_reset;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else if (trap_take) begin
      mepc   <= trap_pc;     // Faulting instruction
      mcause <= trap_cause;
    end else if (sw_write) begin
      case (csr_d)
        csr_mstatus: mstatus <= csr_wdata;
        csr_mtvec:   mtvec   <= csr_wdata;
        csr_mepc:    mepc    <= csr_wdata;
        default: ;           // mcause and IDs not writable here
      endcase
    end
  end

  // ##############################
  // Read mux
  // ##############################

  always_comb begin
    case (csr_s)
      csr_mstatus:   csr_src = mstatus;
      csr_mtvec:     csr_src = mtvec;
      csr_mepc:      csr_src = mepc;
      csr_mcause:    csr_src = mcause;
      csr_mvendorid: csr_src = mvendorid_value;
      csr_marchid:   csr_src = marchid_value;
      default:       csr_src = '0;  // Unimplemented reads as zero
    endcase
  end

  // The trap unit only commits a CSR write when no trap is taken
  trap_excludes_write: assert property (
    @(posedge clock) disable iff (reset)
      !(trap_take && csr_commit)
  );

endmodule

//--- src/gpr_file.sv
module gpr_file (
  input  logic                        clock,
  input  logic                        reset,

  input  logic [4:0]                  rs1,
  input  logic [4:0]                  rs2,
  input  logic [4:0]                  rd,

  input  logic                        wen,
  input  logic                        retire,
  input  logic [commit_pkg::xlen-1:0] wdata,

  output logic [commit_pkg::xlen-1:0] src1,
  output logic [commit_pkg::xlen-1:0] src2
);

  import commit_pkg::*;

  logic [xlen-1:0] regs [reg_count];

  logic [reg_index_width-1:0] rs1_idx;
  logic [reg_index_width-1:0] rs2_idx;
  logic [reg_index_width-1:0] rd_idx;
  logic                       write_en;

  assign rs1_idx = rs1[reg_index_width-1:0];
  assign rs2_idx = rs2[reg_index_width-1:0];
  assign rd_idx  = rd[reg_index_width-1:0];

  // x0 stays zero since it is never written
  assign write_en = wen && retire && (rd_idx != '0);

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < reg_count; i++) begin
        regs[i] <= '0;
      end
    end else if (write_en) begin
      regs[rd_idx] <= wdata;
    end
  end

  assign src1 = regs[rs1_idx];  // Combinational read
  assign src2 = regs[rs2_idx];

  // Zero register reads as zero on either port
  x0_reads_zero: assert property (
    @(posedge clock) disable iff (reset)
      ((rs1_idx == '0) |-> (src1 == '0)) and ((rs2_idx == '0) |-> (src2 == '0))
  );

endmodule

//--- src/commit_pkg.sv
package commit_pkg;

  // ##############################
  // Datapath and register file
  // ##############################

  localparam int xlen            = 32;
  localparam int reg_count       = 16;  // RV32E
  localparam int reg_index_width = 4;   // Upper bit of the 5-bit index is ignored

  // ##############################
  // CSR addresses
  // ##############################

  localparam int csr_addr_width = 12;

  localparam logic [csr_addr_width-1:0] csr_mstatus   = 12'h300;
  localparam logic [csr_addr_width-1:0] csr_mtvec     = 12'h305;
  localparam logic [csr_addr_width-1:0] csr_mepc      = 12'h341;
  localparam logic [csr_addr_width-1:0] csr_mcause    = 12'h342;
  localparam logic [csr_addr_width-1:0] csr_mvendorid = 12'hF11;
  localparam logic [csr_addr_width-1:0] csr_marchid   = 12'hF12;

  // ##############################
  // Reset and constant values
  // ##############################

  localparam logic [xlen-1:0] mstatus_reset   = 32'h0000_1800;  // MPP = machine
  localparam logic [xlen-1:0] mvendorid_value = 32'h7973_7978;
  localparam logic [xlen-1:0] marchid_value   = 32'h017D_9F58;

  localparam logic [xlen-1:0] reset_vector = 32'h8000_0000;

  // ##############################
  // Trap causes
  // ##############################

  localparam logic [xlen-1:0] cause_misaligned = 32'd0;  // Instruction address misaligned
  localparam logic [xlen-1:0] cause_ecall      = 32'd11; // Environment call from M-mode

endpackage
